// ==== design/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

	// datapath width and register count
	localparam int XLEN = 32;
	localparam int NREG = 32;
	// register address width, 5 for 32 regs
	localparam int RADDR_W = $clog2(NREG);

	// the two accepted major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	// funct3 codes, shared by OP and OP-IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct7 picking sub over add, sra over srl
	localparam logic [6:0] F7_ALT = 7'b0100000;

	// alu control codes
	localparam logic [3:0] ALU_OP_ADD  = 4'b0000;
	localparam logic [3:0] ALU_OP_SUB  = 4'b0001;
	localparam logic [3:0] ALU_OP_SLL  = 4'b0010;
	localparam logic [3:0] ALU_OP_SLT  = 4'b0011;
	localparam logic [3:0] ALU_OP_SLTU = 4'b0100;
	localparam logic [3:0] ALU_OP_XOR  = 4'b0101;
	localparam logic [3:0] ALU_OP_SRL  = 4'b0110;
	localparam logic [3:0] ALU_OP_SRA  = 4'b0111;
	localparam logic [3:0] ALU_OP_OR   = 4'b1000;
	localparam logic [3:0] ALU_OP_AND  = 4'b1001;

	// decoder handshake states
	localparam logic [1:0] DEC_IDLE = 2'd0;
	localparam logic [1:0] DEC_BUSY = 2'd1;
	localparam logic [1:0] DEC_ACK  = 2'd2;

	// one instruction word, two views of the same bits
	typedef union packed {
		// register-register form
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		// register-immediate form
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
	} rv_instr_t;

endpackage

`default_nettype wire

// ==== design/uop_if.sv ====
`default_nettype none

// decoded micro-op, decoder to exec stage
interface uop_if import rv_pkg::*; ();

	// one-cycle pulse, payload valid with it
	logic               valid;
	// operands, already selected
	logic [XLEN-1:0]    src1;
	logic [XLEN-1:0]    src2;
	logic [3:0]         alu_control;
	// writeback target
	logic [RADDR_W-1:0] rd;
	// unsupported opcode, no writeback
	logic               illegal;
	// back from exec, cycle after valid
	logic               done;

	// decoder side
	modport dec (
		output valid, src1, src2, alu_control, rd, illegal,
		input  done
	);

	// exec side
	modport exe (
		input  valid, src1, src2, alu_control, rd, illegal,
		output done
	);

endinterface

`default_nettype wire

// ==== design/alu.sv ====
`default_nettype none

module alu import rv_pkg::*; (
	input  wire logic [XLEN-1:0] src1,
	input  wire logic [XLEN-1:0] src2,
	input  wire logic [3:0]      alu_control,
	output logic [XLEN-1:0]      result
);

	logic [4:0]      shamt;
	logic            lt_signed;
	logic            lt_unsigned;
	logic [XLEN-1:0] diff;

	// shifts only look at the low five bits
	assign shamt = src2[4:0];

	// two's complement subtract
	assign diff = src1 + (~src2 + 1'b1);

	// compares for slt / sltu
	assign lt_signed = $signed(src1) < $signed(src2);
	assign lt_unsigned = src1 < src2;

	always_comb begin
		case (alu_control)
			ALU_OP_ADD:  result = src1 + src2;
			ALU_OP_SUB:  result = diff;
			ALU_OP_SLL:  result = src1 << shamt;
			// set-less-than gives 0 or 1
			ALU_OP_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
			ALU_OP_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
			ALU_OP_XOR:  result = src1 ^ src2;
			// logical, zero fill
			ALU_OP_SRL:  result = src1 >> shamt;
			// arithmetic, sign fill
			ALU_OP_SRA:  result = $unsigned($signed(src1) >>> shamt);
			ALU_OP_OR:   result = src1 | src2;
			ALU_OP_AND:  result = src1 & src2;
			// unused codes read as zero
			default:     result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none

module reg_file import rv_pkg::*; (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic [RADDR_W-1:0] rs1_addr,
	input  wire logic [RADDR_W-1:0] rs2_addr,
	output logic [XLEN-1:0]         rs1_data,
	output logic [XLEN-1:0]         rs2_data,
	input  wire logic               we,
	input  wire logic [RADDR_W-1:0] waddr,
	input  wire logic [XLEN-1:0]    wdata
);

	// x0..x31
	logic [XLEN-1:0] regs [NREG];
	logic            wr_ok;

	// x0 stays zero, drop its writes here
	assign wr_ok = we && (waddr != '0);

	// async reads, decoder samples them at capture
	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

	// write at the exec stage's edge
	// reset clears every entry, x0 included
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_ok) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

`default_nettype wire

// ==== design/instr_decode.sv ====
`default_nettype none

module instr_decode import rv_pkg::*; (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               req,
	input  wire rv_instr_t          instr,
	output logic                    ack,
	output logic [RADDR_W-1:0]      rs1_addr,
	output logic [RADDR_W-1:0]      rs2_addr,
	input  wire logic [XLEN-1:0]    rs1_data,
	input  wire logic [XLEN-1:0]    rs2_data,
	uop_if.dec                      uop
);

	logic [1:0]      state;
	logic            take;
	logic            alt;
	logic [XLEN-1:0] imm_sext;
	logic [XLEN-1:0] shamt_ext;
	logic [XLEN-1:0] op2;
	logic [3:0]      alu_code;
	logic            bad_op;

	// register reads straight off the held word
	assign rs1_addr = instr.r.rs1;
	assign rs2_addr = instr.r.rs2;

	// new request accepted only when idle
	assign take = (state == DEC_IDLE) && req;

	// funct7 from r view, also marks srai in the i view
	assign alt = (instr.r.funct7 == F7_ALT);
	assign imm_sext = {{(XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
	// shift amount, low five imm bits
	assign shamt_ext = {{(XLEN-5){1'b0}}, instr.i.imm12[4:0]};

	always_comb begin
		alu_code = ALU_OP_ADD;
		op2 = rs2_data;
		bad_op = 1'b0;
		case (instr.r.opcode)
			OPC_OP: begin
				// second operand from rs2
				case (instr.r.funct3)
					F3_ADD_SUB: alu_code = alt ? ALU_OP_SUB : ALU_OP_ADD;
					F3_SLL:     alu_code = ALU_OP_SLL;
					F3_SLT:     alu_code = ALU_OP_SLT;
					F3_SLTU:    alu_code = ALU_OP_SLTU;
					F3_XOR:     alu_code = ALU_OP_XOR;
					F3_SRL_SRA: alu_code = alt ? ALU_OP_SRA : ALU_OP_SRL;
					F3_OR:      alu_code = ALU_OP_OR;
					F3_AND:     alu_code = ALU_OP_AND;
				endcase
			end
			OPC_OP_IMM: begin
				op2 = imm_sext;
				// no subi, funct3 000 is always addi
				case (instr.i.funct3)
					F3_ADD_SUB: alu_code = ALU_OP_ADD;
					F3_SLL: begin
						alu_code = ALU_OP_SLL;
						op2 = shamt_ext;
					end
					F3_SLT:     alu_code = ALU_OP_SLT;
					F3_SLTU:    alu_code = ALU_OP_SLTU;
					F3_XOR:     alu_code = ALU_OP_XOR;
					F3_SRL_SRA: begin
						alu_code = alt ? ALU_OP_SRA : ALU_OP_SRL;
						op2 = shamt_ext;
					end
					F3_OR:      alu_code = ALU_OP_OR;
					F3_AND:     alu_code = ALU_OP_AND;
				endcase
			end
			// anything else is flagged and not written back
			default: bad_op = 1'b1;
		endcase
	end

	// four-phase handshake, idle -> busy -> acked
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= DEC_IDLE;
			ack <= 1'b0;
			uop.valid <= 1'b0;
		end else begin
			uop.valid <= take;
			case (state)
				DEC_IDLE: if (req) state <= DEC_BUSY;
				DEC_BUSY: begin
					// ack one edge after done
					if (uop.done) begin
						ack <= 1'b1;
						state <= DEC_ACK;
					end
				end
				DEC_ACK: begin
					// hold ack until req seen low
					if (!req) begin
						ack <= 1'b0;
						state <= DEC_IDLE;
					end
				end
				default: state <= DEC_IDLE;
			endcase
		end
	end

	// micro-op payload, captured with the request
	always_ff @(posedge clk) begin
		if (take) begin
			uop.src1 <= rs1_data;
			uop.src2 <= op2;
			uop.alu_control <= alu_code;
			uop.rd <= instr.r.rd;
			uop.illegal <= bad_op;
		end
	end

endmodule

`default_nettype wire

// ==== design/exec_stage.sv ====
`default_nettype none

module exec_stage import rv_pkg::*; (
	input  wire logic               clk,
	input  wire logic               rst,
	uop_if.exe                      uop,
	input  wire logic [XLEN-1:0]    alu_result,
	output logic                    we,
	output logic [RADDR_W-1:0]      waddr,
	output logic [XLEN-1:0]         wdata,
	output logic [XLEN-1:0]         result,
	output logic                    illegal
);

	// writeback data is the registered result
	assign wdata = result;

	// control, one cycle after valid
	always_ff @(posedge clk) begin
		if (rst) begin
			we <= 1'b0;
			uop.done <= 1'b0;
			result <= '0;
			illegal <= 1'b0;
		end else begin
			// single write pulse, suppressed for illegal ops
			we <= uop.valid && !uop.illegal;
			// done echoes valid one cycle later
			uop.done <= uop.valid;
			if (uop.valid) begin
				// illegal reads back as zero
				result <= uop.illegal ? '0 : alu_result;
				illegal <= uop.illegal;
			end
		end
	end

	// target register, held with the result
	always_ff @(posedge clk) begin
		if (uop.valid) begin
			waddr <= uop.rd;
		end
	end

endmodule

`default_nettype wire

// ==== design/rv_exec_top.sv ====
`default_nettype none

module rv_exec_top import rv_pkg::*; (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire logic            req,
	input  wire logic [XLEN-1:0] instr,
	output logic                 ack,
	output logic [XLEN-1:0]      result,
	output logic                 illegal
);

	// register file read side
	logic [RADDR_W-1:0] rs1_addr;
	logic [RADDR_W-1:0] rs2_addr;
	logic [XLEN-1:0]    rs1_data;
	logic [XLEN-1:0]    rs2_data;
	// writeback from exec
	logic               we;
	logic [RADDR_W-1:0] waddr;
	logic [XLEN-1:0]    wdata;
	// combinational alu output
	logic [XLEN-1:0]    alu_result;

	// micro-op link between decode and exec
	uop_if u_uop ();

	// front end, handshake and operand fetch
	instr_decode u_instr_decode (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.instr    (rv_instr_t'(instr)),
		.ack      (ack),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.uop      (u_uop)
	);

	// sits beside decode and exec
	reg_file u_reg_file (
		.clk      (clk),
		.rst      (rst),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.we       (we),
		.waddr    (waddr),
		.wdata    (wdata)
	);

	// operands straight from the registered micro-op
	alu u_alu (
		.src1        (u_uop.src1),
		.src2        (u_uop.src2),
		.alu_control (u_uop.alu_control),
		.result      (alu_result)
	);

	exec_stage u_exec_stage (
		.clk        (clk),
		.rst        (rst),
		.uop        (u_uop),
		.alu_result (alu_result),
		.we         (we),
		.waddr      (waddr),
		.wdata      (wdata),
		.result     (result),
		.illegal    (illegal)
	);

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`default_nettype none

// free-running clock plus power-on reset
module tb_clock (
	output logic clk,
	output logic rst
);

	// period 8
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held through the first four rising edges
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== bench/rv_exec_props.sv ====
`default_nettype none

module rv_exec_props import rv_pkg::*; (
	input wire logic            clk,
	input wire logic            rst,
	input wire logic            req,
	input wire logic            ack,
	input wire logic [XLEN-1:0] result,
	input wire logic            valid
);

	// ack only comes up while a request is pending
	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> req)
		else $error("ack rose without req");

	// ack drops only once req was seen low
	ack_drop_after_req: assert property (@(posedge clk) disable iff (rst)
		$fell(ack) |-> !$past(req))
		else $error("ack fell while req was high");

	// returned value frozen for the whole ack phase
	result_held: assert property (@(posedge clk) disable iff (rst)
		(ack && $past(ack)) |-> $stable(result))
		else $error("result changed while ack high");

	// micro-op valid is a single-cycle pulse
	valid_pulse: assert property (@(posedge clk) disable iff (rst)
		valid |=> !valid)
		else $error("valid high two cycles in a row");

endmodule

// result lives at the top, so attach there
bind rv_exec_top rv_exec_props u_props (
	.clk    (clk),
	.rst    (rst),
	.req    (req),
	.ack    (ack),
	.result (result),
	.valid  (u_uop.valid)
);

`default_nettype wire

// ==== bench/rv_exec_tb.sv ====
`default_nettype none

module rv_exec_tb import rv_pkg::*; ();

	// transaction count over all tests
	localparam int N_TXN = 31 + 36 + 200 + 4 + 12 + 8;
	// watchdog limit in time units
	localparam int TIMEOUT = (N_TXN * 40 + 4) * 8;

	logic            clk;
	logic            rst;
	logic            req;
	rv_instr_t       instr;
	logic            ack;
	logic [XLEN-1:0] result;
	logic            illegal;

	// model state and pending expectations {illegal, result}
	logic [XLEN-1:0] model [NREG];
	logic [XLEN:0]   exp_q [$];
	logic            ack_prev;
	integer          seed = 32'hfdab;
	int              checks = 0;
	int              errors = 0;
	int              test_start = 0;

	tb_clock u_clock (.clk(clk), .rst(rst));

	rv_exec_top u_rv_exec_top (
		.clk     (clk),
		.rst     (rst),
		.req     (req),
		.instr   (instr),
		.ack     (ack),
		.result  (result),
		.illegal (illegal)
	);

	// expected outcome straight from the RV32I rules
	function automatic void ref_exec(inout logic [XLEN-1:0] regs [NREG], input rv_instr_t ins,
			output logic [XLEN-1:0] res, output logic ill);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [4:0]      sh;
		logic            is_imm;
		ill = 1'b0;
		res = '0;
		is_imm = (ins.i.opcode == OPC_OP_IMM);
		if (ins.r.opcode != OPC_OP && !is_imm) begin
			ill = 1'b1;
			return;
		end
		a = regs[ins.r.rs1];
		b = is_imm ? {{20{ins.i.imm12[11]}}, ins.i.imm12} : regs[ins.r.rs2];
		sh = b[4:0];
		case (ins.r.funct3)
			// no subtract in the immediate form
			F3_ADD_SUB: res = (!is_imm && ins.r.funct7 == F7_ALT) ? a - b : a + b;
			F3_SLL:     res = a << sh;
			F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			F3_SLTU:    res = (a < b) ? 32'd1 : 32'd0;
			F3_XOR:     res = a ^ b;
			F3_SRL_SRA: begin
				res = a >> sh;
				// sra copies the sign bit into the vacated top bits
				if (ins.r.funct7 == F7_ALT && a[XLEN-1]) begin
					res = res | ~({XLEN{1'b1}} >> sh);
				end
			end
			F3_OR:      res = a | b;
			default:    res = a & b;
		endcase
		// x0 never changes
		if (ins.r.rd != 5'd0) regs[ins.r.rd] = res;
	endfunction

	function automatic rv_instr_t r_word(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		rv_instr_t w;
		w.r = '{f7, rs2, rs1, f3, rd, OPC_OP};
		return w;
	endfunction

	function automatic rv_instr_t i_word(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd);
		rv_instr_t w;
		w.i = '{imm, rs1, f3, rd, OPC_OP_IMM};
		return w;
	endfunction

	// one four-phase transfer with req held hold extra cycles after ack
	task automatic run_txn(input rv_instr_t w, input int hold);
		logic [XLEN-1:0] exp_res;
		logic            exp_ill;
		logic [XLEN-1:0] held;
		ref_exec(model, w, exp_res, exp_ill);
		exp_q.push_back({exp_ill, exp_res});
		@(posedge clk);
		req <= 1'b1;
		instr <= w;
		@(negedge clk);
		while (!ack) @(negedge clk);
		held = result;
		repeat (hold) begin
			@(negedge clk);
			checks++;
			assert (ack && result == held) else begin
				$display("error: ack %h result %h while req held, expected ack 1 result %h",
					ack, result, held);
				errors++;
			end
		end
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		while (ack) @(negedge clk);
	endtask

	task automatic finish_test(input string name);
		if (errors == test_start) $display("test %s: ok", name);
		else $display("test %s: %0d errors", name, errors - test_start);
		test_start = errors;
	endtask

	// compare mid-cycle at every ack rise
	always @(negedge clk) begin : compare
		logic [XLEN:0] exp;
		if (!rst && ack && !ack_prev) begin
			checks++;
			assert (exp_q.size() != 0) else begin
				$display("ack rose with no instruction outstanding");
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp = exp_q.pop_front();
				checks += 2;
				assert (result == exp[XLEN-1:0]) else begin
					$display("error: result %h expected %h", result, exp[XLEN-1:0]);
					errors++;
				end
				assert (illegal == exp[XLEN]) else begin
					$display("error: illegal %h expected %h", illegal, exp[XLEN]);
					errors++;
				end
			end
		end
		ack_prev = ack;
	end

	initial begin
		#(TIMEOUT);
		$display("timeout: run did not finish in %0d time units", TIMEOUT);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		logic [31:0] rnd;
		logic [2:0]  f3_imm [9];
		logic [11:0] imm;
		rv_instr_t   w;
		req = 1'b0;
		instr = '0;
		ack_prev = 1'b0;
		foreach (model[r]) model[r] = '0;
		// immediate funct3 order with shifts last and srai at the end
		f3_imm = '{F3_ADD_SUB, F3_SLT, F3_SLTU, F3_XOR, F3_OR, F3_AND,
			F3_SLL, F3_SRL_SRA, F3_SRL_SRA};
		@(negedge clk);
		while (rst) @(negedge clk);

		checks++;
		assert (!ack && !illegal && result == '0) else begin
			$display("error: after reset ack %h illegal %h result %h", ack, illegal, result);
			errors++;
		end
		finish_test("reset");

		// known values into x1..x31 first
		for (int r = 1; r < NREG; r++) begin
			rnd = $random(seed);
			run_txn(i_word(rnd[11:0], 5'd0, F3_ADD_SUB, r[4:0]), 0);
		end
		for (int k = 0; k < 9; k++) begin
			for (int j = 0; j < 4; j++) begin
				rnd = $random(seed);
				imm = rnd[21:10];
				if (k >= 6) imm = {(k == 8) ? F7_ALT : 7'd0, rnd[14:10]};
				run_txn(i_word(imm, rnd[4:0], f3_imm[k], rnd[9:5]), 0);
			end
		end
		finish_test("op-imm");

		// funct3 and the alt bit swept over random registers
		for (int i = 0; i < 200; i++) begin
			rnd = $random(seed);
			run_txn(r_word(i[3] ? F7_ALT : 7'd0, rnd[26:22], rnd[4:0], i[2:0], rnd[9:5]), 0);
		end
		finish_test("op");

		// writes to x0 and reads through it
		run_txn(i_word(12'h5a5, 5'd1, F3_ADD_SUB, 5'd0), 0);
		run_txn(r_word(7'd0, 5'd2, 5'd1, F3_ADD_SUB, 5'd0), 0);
		run_txn(r_word(7'd0, 5'd0, 5'd0, F3_OR, 5'd7), 0);
		run_txn(r_word(7'd0, 5'd0, 5'd3, F3_ADD_SUB, 5'd8), 0);
		finish_test("x0");

		// non-OP opcodes each followed by a read of their rd
		for (int i = 0; i < 6; i++) begin
			rnd = $random(seed);
			while (rnd[6:0] == OPC_OP || rnd[6:0] == OPC_OP_IMM) rnd = $random(seed);
			w = rnd;
			run_txn(w, 0);
			run_txn(r_word(7'd0, 5'd0, w.r.rd, F3_ADD_SUB, w.r.rd), 0);
		end
		finish_test("illegal");

		// req held past ack
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			run_txn(r_word(rnd[30] ? F7_ALT : 7'd0, rnd[26:22], rnd[4:0], rnd[12:10],
				rnd[9:5]), int'(rnd[29:27]) + 1);
		end
		finish_test("hold");

		checks++;
		assert (exp_q.size() == 0) else begin
			$display("%0d instructions never got an ack", exp_q.size());
			errors++;
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
design/rv_pkg.sv
design/uop_if.sv
design/alu.sv
design/reg_file.sv
design/instr_decode.sv
design/exec_stage.sv
design/rv_exec_top.sv
bench/tb_clock.sv
bench/rv_exec_props.sv
bench/rv_exec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute slice testbench under verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module rv_exec_tb --Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vrv_exec_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^SIMULATION PASSED$" "$log"; then
	exit 0
fi
echo "pass line not found in $log"
exit 1
